/* beat_counter.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module beat_counter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_i,
    input  logic                      adv_i,
    output logic [`DCACHE_BEAT_W-1:0] beat_o,
    output logic                      last_o
);

    localparam int BEAT_W = `DCACHE_BEAT_W;
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`DCACHE_LINE_WORDS - 1);

    // start wins over advance
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_o <= '0;
        end else if (start_i) begin
            beat_o <= '0;
        end else if (adv_i) begin
            beat_o <= beat_o + 1'b1;
        end
    end

    // final word of the line
    assign last_o = beat_o == LAST_BEAT;

endmodule

/* data_store.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module data_store (
    input  logic                     clk,
    input  dcache_pkg::dcache_addr_u addr_i,
    input  dcache_pkg::access_size_e size_i,
    input  logic [31:0]              wdata_i,
    input  logic                     write_i,
    input  logic                     rd_i,
    input  logic                     wr_i,
    input  logic [`DCACHE_WAY_W-1:0] sel_way_i,
    input  logic [`DCACHE_BEAT_W-1:0] beat_i,
    input  logic                     mem_rvalid_i,
    input  logic [31:0]              mem_rdata_i,
    input  logic [`DCACHE_WAYS-1:0]  hit_way_i,
    output logic [31:0]              rdata_o,
    output logic [31:0]              wb_word_o
);

    logic [3:0][7:0] mem [`DCACHE_WAYS][`DCACHE_SETS][`DCACHE_LINE_WORDS];
    logic [31:0]     rd_q [`DCACHE_WAYS];
    logic [3:0]      be;
    logic [31:0]     wdata_sh;
    logic [31:0]     hit_word;
    logic [31:0]     shifted;
    logic [`DCACHE_INDEX_W-1:0] idx;
    logic [`DCACHE_BEAT_W-1:0]  word;

    assign idx  = addr_i.f.index;
    assign word = addr_i.f.word;

    // store lanes from size and low address bits
    always_comb begin
        case (size_i)
            dcache_pkg::SIZE_WORD: be = 4'b1111;
            dcache_pkg::SIZE_HALF: be = 4'b0011 << {addr_i.f.boff[1], 1'b0};
            default:               be = 4'b0001 << addr_i.f.boff;
        endcase
    end
    assign wdata_sh = wdata_i << {addr_i.f.boff, 3'b000};

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (mem_rvalid_i && int'(sel_way_i) == w) begin
                // refill beat, whole word
                mem[w][idx][beat_i] <= mem_rdata_i;
            end else if (wr_i && hit_way_i[w]) begin
                for (int b = 0; b < 4; b++) begin
                    if (be[b]) begin
                        mem[w][idx][word][b] <= wdata_sh[8*b +: 8];
                    end
                end
            end
            if (rd_i) begin
                rd_q[w] <= mem[w][idx][word];
            end
        end
    end

    // pick the hitting way, then align and zero-extend
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (hit_way_i[w]) begin
                hit_word = hit_word | rd_q[w];
            end
        end
        shifted = hit_word >> {addr_i.f.boff, 3'b000};
        if (write_i) begin
            rdata_o = '0;
        end else begin
            case (size_i)
                dcache_pkg::SIZE_BYTE: rdata_o = {24'b0, shifted[7:0]};
                dcache_pkg::SIZE_HALF: rdata_o = {16'b0, shifted[15:0]};
                default:               rdata_o = hit_word;
            endcase
        end
    end

    // victim word at the current beat
    assign wb_word_o = mem[sel_way_i][idx][beat_i];

endmodule

/* dcache_cfg.svh */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// cache geometry
`define DCACHE_WAYS 2
`define DCACHE_SETS 16
`define DCACHE_LINE_WORDS 4

// derived field widths
`define DCACHE_WAY_W $clog2(`DCACHE_WAYS)
`define DCACHE_INDEX_W $clog2(`DCACHE_SETS)
`define DCACHE_BEAT_W $clog2(`DCACHE_LINE_WORDS)
`define DCACHE_TAG_W (32 - `DCACHE_INDEX_W - `DCACHE_BEAT_W - 2)

// victim selection, must be nonzero
`define DCACHE_LFSR_SEED 8'hB7

`endif

/* dcache_fsm.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_fsm (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      req_valid_i,
    input  logic                                      req_write_i,
    input  dcache_pkg::dcache_addr_u                  req_addr_i,
    input  dcache_pkg::access_size_e                  req_size_i,
    input  logic [31:0]                               req_wdata_i,
    input  logic                                      resp_ready_i,
    input  logic                                      mem_req_ready_i,
    input  logic                                      mem_wready_i,
    input  logic                                      mem_rvalid_i,
    input  logic                                      mem_rlast_i,
    input  logic [`DCACHE_WAYS-1:0]                   hit_way_i,
    input  dcache_pkg::tag_entry_t [`DCACHE_WAYS-1:0] lookup_entry_i,
    input  logic [`DCACHE_BEAT_W-1:0]                 beat_i,
    input  logic                                      beat_last_i,
    output logic                                      req_ready_o,
    output logic                                      resp_valid_o,
    output logic                                      mem_req_valid_o,
    output logic                                      mem_req_write_o,
    output logic [31:0]                               mem_req_addr_o,
    output logic                                      mem_wvalid_o,
    output logic                                      mem_wlast_o,
    output dcache_pkg::dcache_addr_u                  cur_addr_o,
    output dcache_pkg::access_size_e                  cur_size_o,
    output logic [31:0]                               cur_wdata_o,
    output logic                                      cur_write_o,
    output logic                                      beat_start_o,
    output logic                                      beat_adv_o,
    output logic                                      tag_we_o,
    output logic [`DCACHE_WAY_W-1:0]                  tag_wr_way_o,
    output dcache_pkg::tag_entry_t                    tag_wr_entry_o,
    output logic                                      data_rd_o,
    output logic                                      data_wr_o,
    output logic [`DCACHE_WAY_W-1:0]                  data_sel_way_o
);

    localparam int WAY_W = `DCACHE_WAY_W;

    dcache_pkg::cache_state_e state_q;
    dcache_pkg::cache_state_e state_d;
    dcache_pkg::dcache_addr_u addr_q;
    dcache_pkg::access_size_e size_q;
    dcache_pkg::tag_entry_t   wb_entry;
    logic [31:0]              wdata_q;
    logic                     write_q;
    logic [7:0]               lfsr_q;
    logic [WAY_W-1:0]         lfsr_way;
    logic [WAY_W-1:0]         victim_q;
    logic [WAY_W-1:0]         hit_idx;
    logic                     st_idle;
    logic                     st_lookup;
    logic                     st_fill;
    logic                     hit;
    logic                     victim_dirty;
    logic                     rf_done;

    assign st_idle   = state_q == dcache_pkg::ST_IDLE;
    assign st_lookup = state_q == dcache_pkg::ST_LOOKUP;
    assign st_fill   = state_q == dcache_pkg::ST_FILL_WAIT;
    assign hit       = |hit_way_i;
    assign lfsr_way  = lfsr_q[WAY_W-1:0];
    assign wb_entry  = lookup_entry_i[victim_q];

    // a clean or empty victim skips the write-back
    assign victim_dirty = lookup_entry_i[lfsr_way].valid && lookup_entry_i[lfsr_way].dirty;

    // rlast normally ends the burst, beat count as backup
    assign rf_done = state_q == dcache_pkg::ST_RF_DATA && mem_rvalid_i
                     && (mem_rlast_i || beat_last_i);

    // one-hot hit vector to way number
    always_comb begin
        hit_idx = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (hit_way_i[w]) begin
                hit_idx = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= dcache_pkg::ST_IDLE;
            lfsr_q  <= `DCACHE_LFSR_SEED;
        end else begin
            state_q <= state_d;
            // x^8 + x^6 + x^5 + x^4 + 1, free running
            lfsr_q  <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

    // accepted request and chosen victim
    always_ff @(posedge clk) begin
        if (st_idle && req_valid_i) begin
            addr_q  <= req_addr_i;
            size_q  <= req_size_i;
            wdata_q <= req_wdata_i;
            write_q <= req_write_i;
        end
        if (st_lookup && !hit) begin
            victim_q <= lfsr_way;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::ST_IDLE: begin
                if (req_valid_i) begin
                    state_d = dcache_pkg::ST_LOOKUP;
                end
            end
            dcache_pkg::ST_LOOKUP: begin
                if (hit) begin
                    state_d = resp_ready_i ? dcache_pkg::ST_IDLE : dcache_pkg::ST_RESPOND;
                end else if (victim_dirty) begin
                    state_d = dcache_pkg::ST_WB_ADDR;
                end else begin
                    state_d = dcache_pkg::ST_RF_ADDR;
                end
            end
            dcache_pkg::ST_WB_ADDR: begin
                if (mem_req_ready_i) begin
                    state_d = dcache_pkg::ST_WB_DATA;
                end
            end
            dcache_pkg::ST_WB_DATA: begin
                if (mem_wready_i && mem_wlast_o) begin
                    state_d = dcache_pkg::ST_RF_ADDR;
                end
            end
            dcache_pkg::ST_RF_ADDR: begin
                if (mem_req_ready_i) begin
                    state_d = dcache_pkg::ST_RF_DATA;
                end
            end
            dcache_pkg::ST_RF_DATA: begin
                if (rf_done) begin
                    state_d = dcache_pkg::ST_FILL_WAIT;
                end
            end
            // tag goes in now, lookup then repeats as a hit
            dcache_pkg::ST_FILL_WAIT: state_d = dcache_pkg::ST_LOOKUP;
            dcache_pkg::ST_RESPOND: begin
                if (resp_ready_i) begin
                    state_d = dcache_pkg::ST_IDLE;
                end
            end
            default: state_d = dcache_pkg::ST_IDLE;
        endcase
    end

    assign req_ready_o     = st_idle;
    assign resp_valid_o    = (st_lookup && hit) || state_q == dcache_pkg::ST_RESPOND;
    assign mem_req_valid_o = state_q == dcache_pkg::ST_WB_ADDR
                             || state_q == dcache_pkg::ST_RF_ADDR;
    assign mem_req_write_o = state_q == dcache_pkg::ST_WB_ADDR;
    assign mem_wvalid_o    = state_q == dcache_pkg::ST_WB_DATA;
    assign mem_wlast_o     = mem_wvalid_o && (&beat_i);

    // line-aligned, victim tag for write-back
    assign mem_req_addr_o = {mem_req_write_o ? wb_entry.tag : addr_q.f.tag,
                             addr_q.f.index, {(`DCACHE_BEAT_W + 2){1'b0}}};

    // the stores read the incoming address while idle
    assign cur_addr_o  = st_idle ? req_addr_i : addr_q;
    assign cur_size_o  = size_q;
    assign cur_wdata_o = wdata_q;
    assign cur_write_o = write_q;

    assign beat_start_o = mem_req_valid_o && mem_req_ready_i;
    assign beat_adv_o   = (mem_wvalid_o && mem_wready_i)
                          || (state_q == dcache_pkg::ST_RF_DATA && mem_rvalid_i);

    // write hit marks dirty, refill installs clean
    assign tag_we_o     = (st_lookup && hit && write_q) || st_fill;
    assign tag_wr_way_o = st_fill ? victim_q : hit_idx;
    always_comb begin
        tag_wr_entry_o.valid = 1'b1;
        tag_wr_entry_o.dirty = !st_fill;
        tag_wr_entry_o.tag   = addr_q.f.tag;
    end

    assign data_rd_o      = st_idle || st_fill;
    assign data_wr_o      = st_lookup && hit && write_q;
    assign data_sel_way_o = victim_q;

endmodule

/* dcache_pkg.sv */
`include "dcache_cfg.svh"

package dcache_pkg;

    // load/store access width
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_e;

    // request address, seen as a raw word or split for the cache
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [`DCACHE_TAG_W-1:0]   tag;
            logic [`DCACHE_INDEX_W-1:0] index;
            logic [`DCACHE_BEAT_W-1:0]  word;
            logic [1:0]                 boff;
        } f;
    } dcache_addr_u;

    typedef struct packed {
        logic                     valid;
        logic                     dirty;
        logic [`DCACHE_TAG_W-1:0] tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WB_ADDR,
        ST_WB_DATA,
        ST_RF_ADDR,
        ST_RF_DATA,
        ST_FILL_WAIT,
        ST_RESPOND
    } cache_state_e;

endpackage

/* dcache_properties.sv */
`timescale 1ns/1ps

module dcache_properties (
    input logic        clk,
    input logic        rst_n,
    input logic        req_ready_o,
    input logic        resp_valid_o,
    input logic        resp_ready_i,
    input logic [31:0] resp_rdata_o,
    input logic        mem_req_valid_o,
    input logic        mem_req_ready_i,
    input logic [31:0] mem_req_addr_o,
    input logic        mem_wvalid_o
);

    // response held with stable data until taken
    assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_rdata_o))
        else $error("response dropped or changed before resp_ready_i");

    // memory request held with stable address until taken
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_addr_o))
        else $error("memory request dropped or changed before mem_req_ready_i");

    assert property (@(posedge clk) disable iff (!rst_n)
        !(req_ready_o && resp_valid_o))
        else $error("req_ready_o high while a response is pending");

    // outputs quiet in the cycle after reset
    assert property (@(posedge clk)
        !rst_n |=> !(resp_valid_o || mem_req_valid_o || mem_wvalid_o))
        else $error("valid output high right after reset");

endmodule

bind dcache_top dcache_properties u_props (.*);

/* dcache_top.f */
+incdir+.
dcache_pkg.sv
beat_counter.sv
tag_store.sv
data_store.sv
dcache_fsm.sv
dcache_top.sv
dcache_properties.sv
tb_dcache_top.sv

/* dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid_i,
    output logic                     req_ready_o,
    input  logic                     req_write_i,
    input  dcache_pkg::dcache_addr_u req_addr_i,
    input  dcache_pkg::access_size_e req_size_i,
    input  logic [31:0]              req_wdata_i,
    output logic                     resp_valid_o,
    input  logic                     resp_ready_i,
    output logic [31:0]              resp_rdata_o,
    output logic                     mem_req_valid_o,
    input  logic                     mem_req_ready_i,
    output logic                     mem_req_write_o,
    output logic [31:0]              mem_req_addr_o,
    output logic                     mem_wvalid_o,
    input  logic                     mem_wready_i,
    output logic [31:0]              mem_wdata_o,
    output logic                     mem_wlast_o,
    input  logic                     mem_rvalid_i,
    input  logic [31:0]              mem_rdata_i,
    input  logic                     mem_rlast_i
);

    dcache_pkg::dcache_addr_u                     cur_addr;
    dcache_pkg::access_size_e                     cur_size;
    logic [31:0]                                  cur_wdata;
    logic                                         cur_write;
    logic                                         beat_start;
    logic                                         beat_adv;
    logic [`DCACHE_BEAT_W-1:0]                    beat;
    logic                                         beat_last;
    logic                                         tag_we;
    logic [`DCACHE_WAY_W-1:0]                     tag_wr_way;
    dcache_pkg::tag_entry_t                       tag_wr_entry;
    dcache_pkg::tag_entry_t [`DCACHE_WAYS-1:0]    lookup_entry;
    logic [`DCACHE_WAYS-1:0]                      hit_way;
    logic                                         data_rd;
    logic                                         data_wr;
    logic [`DCACHE_WAY_W-1:0]                     sel_way;

    dcache_fsm u_fsm (
        .clk(clk),
        .rst_n(rst_n),
        .req_valid_i(req_valid_i),
        .req_write_i(req_write_i),
        .req_addr_i(req_addr_i),
        .req_size_i(req_size_i),
        .req_wdata_i(req_wdata_i),
        .resp_ready_i(resp_ready_i),
        .mem_req_ready_i(mem_req_ready_i),
        .mem_wready_i(mem_wready_i),
        .mem_rvalid_i(mem_rvalid_i),
        .mem_rlast_i(mem_rlast_i),
        .hit_way_i(hit_way),
        .lookup_entry_i(lookup_entry),
        .beat_i(beat),
        .beat_last_i(beat_last),
        .req_ready_o(req_ready_o),
        .resp_valid_o(resp_valid_o),
        .mem_req_valid_o(mem_req_valid_o),
        .mem_req_write_o(mem_req_write_o),
        .mem_req_addr_o(mem_req_addr_o),
        .mem_wvalid_o(mem_wvalid_o),
        .mem_wlast_o(mem_wlast_o),
        .cur_addr_o(cur_addr),
        .cur_size_o(cur_size),
        .cur_wdata_o(cur_wdata),
        .cur_write_o(cur_write),
        .beat_start_o(beat_start),
        .beat_adv_o(beat_adv),
        .tag_we_o(tag_we),
        .tag_wr_way_o(tag_wr_way),
        .tag_wr_entry_o(tag_wr_entry),
        .data_rd_o(data_rd),
        .data_wr_o(data_wr),
        .data_sel_way_o(sel_way)
    );

    beat_counter u_beat (
        .clk(clk),
        .rst_n(rst_n),
        .start_i(beat_start),
        .adv_i(beat_adv),
        .beat_o(beat),
        .last_o(beat_last)
    );

    tag_store u_tags (
        .clk(clk),
        .rst_n(rst_n),
        .rd_addr_i(cur_addr),
        .we_i(tag_we),
        .wr_way_i(tag_wr_way),
        .wr_entry_i(tag_wr_entry),
        .entry_o(lookup_entry),
        .hit_way_o(hit_way)
    );

    data_store u_data (
        .clk(clk),
        .addr_i(cur_addr),
        .size_i(cur_size),
        .wdata_i(cur_wdata),
        .write_i(cur_write),
        .rd_i(data_rd),
        .wr_i(data_wr),
        .sel_way_i(sel_way),
        .beat_i(beat),
        .mem_rvalid_i(mem_rvalid_i),
        .mem_rdata_i(mem_rdata_i),
        .hit_way_i(hit_way),
        .rdata_o(resp_rdata_o),
        .wb_word_o(mem_wdata_o)
    );

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -f dcache_top.f --top-module tb_dcache_top -o sim_dcache
./obj_dir/sim_dcache | tee sim.log

if grep -q "^ALL CHECKS PASSED$" sim.log; then
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi

/* tag_store.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module tag_store (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  dcache_pkg::dcache_addr_u                  rd_addr_i,
    input  logic                                      we_i,
    input  logic [`DCACHE_WAY_W-1:0]                  wr_way_i,
    input  dcache_pkg::tag_entry_t                    wr_entry_i,
    output dcache_pkg::tag_entry_t [`DCACHE_WAYS-1:0] entry_o,
    output logic [`DCACHE_WAYS-1:0]                   hit_way_o
);

    logic [`DCACHE_SETS-1:0]   valid_q [`DCACHE_WAYS];
    logic [`DCACHE_SETS-1:0]   dirty_q [`DCACHE_WAYS];
    logic [`DCACHE_TAG_W-1:0]  tag_mem [`DCACHE_WAYS][`DCACHE_SETS];
    logic [`DCACHE_INDEX_W-1:0] idx;
    dcache_pkg::dcache_addr_u  addr_q;

    // writes always target the set being looked up
    assign idx = rd_addr_i.f.index;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
        end else if (we_i) begin
            valid_q[wr_way_i][idx] <= wr_entry_i.valid;
            dirty_q[wr_way_i][idx] <= wr_entry_i.dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_mem[wr_way_i][idx] <= wr_entry_i.tag;
        end
    end

    // registered read, new entry forwarded on a same-edge write
    always_ff @(posedge clk) begin
        addr_q <= rd_addr_i;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (we_i && int'(wr_way_i) == w) begin
                entry_o[w] <= wr_entry_i;
            end else begin
                entry_o[w].valid <= valid_q[w][idx];
                entry_o[w].dirty <= dirty_q[w][idx];
                entry_o[w].tag   <= tag_mem[w][idx];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            hit_way_o[w] = entry_o[w].valid && entry_o[w].tag == addr_q.f.tag;
        end
    end

endmodule

/* tb_dcache_top.sv */
`timescale 1ns/1ps

module tb_dcache_top;

    localparam int TIMEOUT = 300;
    localparam logic [31:0] FILL_KEY = 32'h5A3C_96E1;

    typedef struct {
        bit                       is_write;
        logic [31:0]              addr;
        dcache_pkg::access_size_e size;
        logic [31:0]              wdata;
        int                       exp_rf;
        int                       exp_wb;
        bit                       chk_hit;
        string                    name;
    } test_t;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic req_valid_i = 1'b0;
    logic req_ready_o;
    logic req_write_i = 1'b0;
    dcache_pkg::dcache_addr_u req_addr_i = '0;
    dcache_pkg::access_size_e req_size_i = dcache_pkg::SIZE_WORD;
    logic [31:0] req_wdata_i = '0;
    logic resp_valid_o;
    logic resp_ready_i = 1'b0;
    logic [31:0] resp_rdata_o;
    logic mem_req_valid_o;
    logic mem_req_ready_i = 1'b0;
    logic mem_req_write_o;
    logic [31:0] mem_req_addr_o;
    logic mem_wvalid_o;
    logic mem_wready_i = 1'b0;
    logic [31:0] mem_wdata_o;
    logic mem_wlast_o;
    logic mem_rvalid_i = 1'b0;
    logic [31:0] mem_rdata_i = '0;
    logic mem_rlast_i = 1'b0;

    logic [31:0] mem_words [logic [31:0]];
    logic [7:0]  shadow [logic [31:0]];
    test_t       tests [$];
    int          error_count = 0;
    int          rf_count = 0;
    int          wb_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    logic [31:0] last_rf_addr = '0;
    bit          sim_done = 1'b0;

    dcache_top UUT (.*);

    always #2 clk = ~clk;

    task automatic timeout_fail(input string what);
        $display("Error: timeout waiting for %s", what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic compare_rdata(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Mismatch %s expected %08h actual %08h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic compare_wb_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Mismatch %s write-back bursts expected %0d actual %0d", name, exp, act);
            error_count++;
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Mismatch %s expected %0d actual %0d", name, exp, act);
            error_count++;
        end
    endtask

    function automatic logic [31:0] mem_read(input logic [31:0] a);
        if (mem_words.exists(a)) return mem_words[a];
        return a ^ FILL_KEY;
    endfunction

    function automatic logic [7:0] shadow_byte(input logic [31:0] a);
        logic [31:0] w;
        if (shadow.exists(a)) return shadow[a];
        w = {a[31:2], 2'b00} ^ FILL_KEY;
        return w[8*a[1:0] +: 8];
    endfunction

    function automatic int size_bytes(input dcache_pkg::access_size_e s);
        if (s == dcache_pkg::SIZE_BYTE) return 1;
        if (s == dcache_pkg::SIZE_HALF) return 2;
        return 4;
    endfunction

    function automatic logic [31:0] expected_read(input logic [31:0] a, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = shadow_byte(a + i);
        end
        return v;
    endfunction

    task automatic step;
        @(posedge clk);
        #1;
    endtask

    // one memory transaction with its address handshake and burst
    task automatic serve_mem;
        logic [31:0] base;
        logic        wr;
        int          t;
        repeat ($urandom_range(3, 0)) step();
        step();
        mem_req_ready_i = 1'b1;
        @(negedge clk);
        base = mem_req_addr_o;
        wr = mem_req_write_o;
        step();
        mem_req_ready_i = 1'b0;
        for (int i = 0; i < 4; i++) begin
            repeat ($urandom_range(3, 0)) step();
            if (wr) begin
                mem_wready_i = 1'b1;
                t = 0;
                @(negedge clk);
                while (!mem_wvalid_o) begin
                    t++;
                    if (t > TIMEOUT) timeout_fail("mem_wvalid_o");
                    @(negedge clk);
                end
                // evicted line must match the shadow contents
                compare_rdata("writeback_word", expected_read(base + 4 * i, 4), mem_wdata_o);
                compare_count("writeback_wlast", (i == 3) ? 1 : 0, int'(mem_wlast_o));
                mem_words[base + 4 * i] = mem_wdata_o;
                step();
                mem_wready_i = 1'b0;
            end else begin
                mem_rvalid_i = 1'b1;
                mem_rdata_i = mem_read(base + 4 * i);
                mem_rlast_i = (i == 3);
                step();
                mem_rvalid_i = 1'b0;
                mem_rlast_i = 1'b0;
            end
        end
        if (wr) begin
            wb_count++;
            $display("write-back burst at %08h", base);
        end else begin
            rf_count++;
            last_rf_addr = base;
        end
    endtask

    initial begin
        int t;
        t = 0;
        while (!sim_done) begin
            @(negedge clk);
            if (rst_n && mem_req_valid_o) begin
                serve_mem();
            end
            t++;
            if (t > 100000) timeout_fail("end of run");
        end
    end

    task automatic do_request(input test_t tc, output logic [31:0] rdata, output int lat);
        int t;
        req_valid_i = 1'b1;
        req_write_i = tc.is_write;
        req_addr_i.raw = tc.addr;
        req_size_i = tc.size;
        req_wdata_i = tc.wdata;
        t = 0;
        @(negedge clk);
        while (!req_ready_o) begin
            t++;
            if (t > TIMEOUT) timeout_fail("req_ready_o");
            @(negedge clk);
        end
        step();
        req_valid_i = 1'b0;
        lat = 0;
        t = 0;
        forever begin
            resp_ready_i = ($urandom_range(3, 0) != 0);
            @(negedge clk);
            t++;
            if (resp_valid_o && lat == 0) lat = t;
            if (resp_valid_o && resp_ready_i) break;
            if (t > TIMEOUT) timeout_fail("resp_valid_o");
            step();
        end
        rdata = resp_rdata_o;
        step();
        resp_ready_i = 1'b0;
    endtask

    initial begin
        logic [31:0] rdata;
        logic [31:0] exp;
        int lat;
        int rf0;
        int wb0;
        int err0;
        int n;
        void'($urandom(65526));
        tests.push_back('{0, 32'h1030, dcache_pkg::SIZE_WORD, 0, 1, 0, 0, "rd_miss"});
        tests.push_back('{0, 32'h1034, dcache_pkg::SIZE_WORD, 0, 0, 0, 1, "rd_hit"});
        tests.push_back('{1, 32'h1034, dcache_pkg::SIZE_BYTE, 32'hAB, 0, 0, 1, "wr_b0"});
        tests.push_back('{1, 32'h1035, dcache_pkg::SIZE_BYTE, 32'hCD, 0, 0, 1, "wr_b1"});
        tests.push_back('{1, 32'h1036, dcache_pkg::SIZE_BYTE, 32'hEF, 0, 0, 1, "wr_b2"});
        tests.push_back('{1, 32'h1037, dcache_pkg::SIZE_BYTE, 32'h12, 0, 0, 1, "wr_b3"});
        tests.push_back('{0, 32'h1034, dcache_pkg::SIZE_WORD, 0, 0, 0, 1, "rd_merge_b"});
        tests.push_back('{1, 32'h1038, dcache_pkg::SIZE_HALF, 32'hBEEF, 0, 0, 1, "wr_h0"});
        tests.push_back('{1, 32'h103A, dcache_pkg::SIZE_HALF, 32'h5566, 0, 0, 1, "wr_h1"});
        tests.push_back('{0, 32'h1038, dcache_pkg::SIZE_WORD, 0, 0, 0, 1, "rd_merge_h"});
        tests.push_back('{0, 32'h103A, dcache_pkg::SIZE_HALF, 0, 0, 0, 1, "rd_half"});
        tests.push_back('{0, 32'h1037, dcache_pkg::SIZE_BYTE, 0, 0, 0, 1, "rd_byte"});
        tests.push_back('{1, 32'h2030, dcache_pkg::SIZE_WORD, 32'hDEADBEEF, 1, -1, 0, "wr_set3_b"});
        tests.push_back('{1, 32'h3030, dcache_pkg::SIZE_WORD, 32'hCAFEF00D, 1, -1, 0, "wr_set3_c"});
        tests.push_back('{1, 32'h4030, dcache_pkg::SIZE_WORD, 32'h01234567, 1, -1, 0, "wr_set3_d"});
        tests.push_back('{0, 32'h1034, dcache_pkg::SIZE_WORD, 0, -1, -1, 0, "rd_evicted_a"});
        tests.push_back('{0, 32'h2030, dcache_pkg::SIZE_WORD, 0, -1, -1, 0, "rd_evicted_b"});
        tests.push_back('{0, 32'h3030, dcache_pkg::SIZE_WORD, 0, -1, -1, 0, "rd_evicted_c"});
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        step();
        foreach (tests[k]) begin
            rf0 = rf_count;
            wb0 = wb_count;
            err0 = error_count;
            do_request(tests[k], rdata, lat);
            n = size_bytes(tests[k].size);
            exp = tests[k].is_write ? 32'h0 : expected_read(tests[k].addr, n);
            compare_rdata(tests[k].name, exp, rdata);
            if (tests[k].is_write) begin
                for (int i = 0; i < n; i++) begin
                    shadow[tests[k].addr + i] = tests[k].wdata[8*i +: 8];
                end
            end
            if (tests[k].exp_rf >= 0) compare_count({tests[k].name, " refills"},
                                                     tests[k].exp_rf, rf_count - rf0);
            if (tests[k].exp_wb >= 0) compare_wb_count(tests[k].name, tests[k].exp_wb,
                                                       wb_count - wb0);
            if (tests[k].chk_hit) compare_count({tests[k].name, " hit latency"}, 1, lat);
            if (k == 0) compare_rdata("rd_miss refill addr", tests[k].addr & 32'hFFFF_FFF0,
                                      last_rf_addr);
            if (error_count == err0) begin
                pass_count++;
                $display("test %s ok", tests[k].name);
            end else begin
                fail_count++;
                $display("test %s failed", tests[k].name);
            end
        end
        // set 3 holds only two ways, so the dirty lines force an eviction
        if (wb_count < 1) begin
            $display("Error: no write-back burst was seen");
            error_count++;
        end
        sim_done = 1'b1;
        $display("tests passed %0d failed %0d errors %0d", pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
